//--- tb.f
rtl/elk_mem_pkg.sv
rtl/bank_if.sv
rtl/addr_decode.sv
rtl/swram_bank.sv
rtl/rom_store.sv
rtl/read_mux.sv
rtl/elk_mem_top.sv
dv/tb_elk_mem.sv

//--- Bender.yml
package:
  name: elk_mem

sources:
  - files:
      - rtl/elk_mem_pkg.sv
      - rtl/bank_if.sv
      - rtl/addr_decode.sv
      - rtl/swram_bank.sv
      - rtl/rom_store.sv
      - rtl/read_mux.sv
      - rtl/elk_mem_top.sv
  - target: test
    files:
      - dv/tb_elk_mem.sv

//--- dv/tb_elk_mem.sv
/*
 * Testbench for the Electron external memory map
 * Clock, reset, bus and download tasks, ROM and RAM reference model,
 * concurrent check of the read data
 */

`timescale 1ns/1ps

module tb_elk_mem import elk_mem_pkg::*; ();

	logic                    clk_sys;
	logic                    rst;
	logic [BUS_ADDR_W-1:0]   cpu_addr;
	logic                    cpu_we_n;
	logic [DATA_W-1:0]       cpu_din;
	logic [DATA_W-1:0]       cpu_dout;
	logic                    load_wr;
	logic [LOAD_INDEX_W-1:0] load_index;
	logic [ROM_ADDR_W-1:0]   load_addr;
	logic [DATA_W-1:0]       load_data;

	// Reference memories
	logic [DATA_W-1:0]     rom_model [ROM_BYTES];
	logic [DATA_W-1:0]     ram_model [RAM_BANKS][PAGE_BYTES];
	logic [BUS_ADDR_W-1:0] ram_written [$];
	logic [ROM_ADDR_W-1:0] rom_rejected [$];
	int                    offs [34];

	// Check pipeline where a pending entry goes active on the next falling edge
	logic              chk_en;
	logic [DATA_W-1:0] exp_dout;
	string             test_name;
	logic              pend_chk;
	logic [DATA_W-1:0] pend_exp;
	string             pend_name;
	// nWE as the DUT saw it on the last rising edge
	logic              we_hist;

	int check_count;
	int check_errors;
	int timeout_errors;

	elk_mem_top u_dut (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.cpu_addr   (cpu_addr),
		.cpu_we_n   (cpu_we_n),
		.cpu_din    (cpu_din),
		.cpu_dout   (cpu_dout),
		.load_wr    (load_wr),
		.load_index (load_index),
		.load_addr  (load_addr),
		.load_data  (load_data)
	);

	initial begin
		clk_sys = 1'b0;
		forever begin
			#50 clk_sys = ~clk_sys;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Output check
	//////////////////////////////////////////////////////////////////////

	// cpu_dout for the address sampled one edge earlier
	property dout_matches_model;
		@(posedge clk_sys) chk_en |-> (cpu_dout == exp_dout);
	endproperty

	dout_check: assert property (dout_matches_model)
	else begin
		check_errors++;
		$display("CHECK FAILED %s: expected %02h actual %02h",
			test_name, $sampled(exp_dout), $sampled(cpu_dout));
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	// Page to slot number or -1 when unmapped
	function automatic int page_slot(input logic [3:0] page);
		case (page)
			4'b0100:          return 0;
			4'b1000, 4'b1001: return 1;
			4'b1010, 4'b1011: return 2;
			4'b1100:          return 3;
			4'b1101:          return 4;
			4'b1110:          return 5;
			4'b1111:          return 6;
			default:          return -1;
		endcase
	endfunction

	// First page that maps a slot
	function automatic logic [3:0] slot_page(input logic [2:0] slot);
		case (slot)
			3'd0:    return 4'b0100;
			3'd1:    return 4'b1000;
			3'd2:    return 4'b1010;
			3'd3:    return 4'b1100;
			3'd4:    return 4'b1101;
			3'd5:    return 4'b1110;
			default: return 4'b1111;
		endcase
	endfunction

	function automatic logic [DATA_W-1:0] model_read(input logic [BUS_ADDR_W-1:0] addr);
		int slot;
		slot = page_slot(addr[17:14]);
		if (addr[18]) begin
			// Upper half of the RAM window is empty
			return addr[17] ? '0 : ram_model[addr[16:14]][addr[13:0]];
		end else if (slot < 0) begin
			return '0;
		end else begin
			return rom_model[slot * PAGE_BYTES + addr[13:0]];
		end
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Stimulus tasks entered before a falling edge
	//////////////////////////////////////////////////////////////////////

	task automatic advance_cycle(input logic chk, input logic [DATA_W-1:0] exp,
			input string name);
		chk_en    = pend_chk;
		exp_dout  = pend_exp;
		test_name = pend_name;
		if (pend_chk) begin
			check_count++;
		end
		pend_chk  = chk;
		pend_exp  = exp;
		pend_name = name;
		// DUT holds its nWE history high in reset
		we_hist   = rst ? 1'b1 : cpu_we_n;
	endtask

	// One bus cycle whose read is checked a cycle later
	task automatic bus_cycle(input logic [BUS_ADDR_W-1:0] addr, input logic we_n,
			input logic [DATA_W-1:0] din, input string name);
		@(negedge clk_sys);
		cpu_addr = addr;
		cpu_we_n = we_n;
		cpu_din  = din;
		load_wr  = 1'b0;
		// High to low nWE outside reset writes the lower RAM window only
		if (!rst && we_hist && !we_n && addr[18] && !addr[17]) begin
			ram_model[addr[16:14]][addr[13:0]] = din;
		end
		if (rst) begin
			advance_cycle(1'b1, '0, "reset_out");
		end else begin
			advance_cycle(we_n, model_read(addr), name);
		end
	endtask

	// Write, then release nWE and read the byte back
	task automatic ram_write(input logic [BUS_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
			input string name);
		bus_cycle(addr, 1'b0, data, name);
		bus_cycle(addr, 1'b1, '0, name);
	endtask

	task automatic load_strobe(input logic [LOAD_INDEX_W-1:0] idx,
			input logic [ROM_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		@(negedge clk_sys);
		load_wr    = 1'b1;
		load_index = idx;
		load_addr  = addr;
		load_data  = data;
		// Running core points at the same ROM byte so a stray write would show
		if (!rst) begin
			cpu_addr = {1'b0, slot_page(addr[16:14]), addr[13:0]};
		end
		// Index zero during reset is the ROM image
		if (rst && idx == '0) begin
			rom_model[addr] = data;
		end
		advance_cycle(rst, '0, "reset_out");
	endtask

	task automatic begin_reset();
		for (int i = 0; i < 5; i++) begin
			@(negedge clk_sys);
			rst     = 1'b1;
			load_wr = 1'b0;
			advance_cycle(1'b1, '0, "reset_out");
		end
	endtask

	// Last reset cycle's zero check covers the first cycle after release
	task automatic end_reset();
		@(negedge clk_sys);
		rst     = 1'b0;
		load_wr = 1'b0;
		advance_cycle(1'b0, '0, "");
	endtask

	task automatic drain_checks();
		int n;
		n = 0;
		while (chk_en || pend_chk) begin
			if (n == 8) begin
				timeout_errors++;
				$display("Timeout: output checks still pending after %0d cycles", n);
				return;
			end
			@(negedge clk_sys);
			advance_cycle(1'b0, '0, "");
			n++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		logic [BUS_ADDR_W-1:0] a;
		logic [ROM_ADDR_W-1:0] ra;
		int                    off;
		void'($urandom(35988));
		rst        = 1'b1;
		cpu_addr   = {1'b0, 4'b1000, 14'h0};
		cpu_we_n   = 1'b1;
		cpu_din    = '0;
		load_wr    = 1'b0;
		load_index = '0;
		load_addr  = '0;
		load_data  = '0;
		chk_en     = 1'b0;
		exp_dout   = '0;
		test_name  = "";
		pend_chk   = 1'b0;
		pend_exp   = '0;
		pend_name  = "";
		we_hist    = 1'b1;
		check_count    = 0;
		check_errors   = 0;
		timeout_errors = 0;

		// Power-on reset
		begin_reset();
		end_reset();

		// Full ROM image followed by other indexes that must be ignored
		begin_reset();
		for (int i = 0; i < ROM_BYTES; i++) begin
			load_strobe('0, ROM_ADDR_W'(i), DATA_W'($urandom));
		end
		for (int i = 0; i < 64; i++) begin
			rom_rejected.push_back(ROM_ADDR_W'($urandom % ROM_BYTES));
			load_strobe(LOAD_INDEX_W'(1 + $urandom % 255), rom_rejected[$], DATA_W'($urandom));
		end
		end_reset();
		// Index zero but core running
		for (int i = 0; i < 64; i++) begin
			rom_rejected.push_back(ROM_ADDR_W'($urandom % ROM_BYTES));
			load_strobe('0, rom_rejected[$], DATA_W'($urandom));
		end

		// Every page with aliases reading the same offsets
		for (int i = 0; i < 34; i++) begin
			offs[i] = (i == 0) ? 0 : (i == 1) ? PAGE_BYTES - 1 : int'($urandom % PAGE_BYTES);
		end
		for (int p = 0; p < 16; p++) begin
			for (int i = 0; i < 34; i++) begin
				a = {1'b0, 4'(p), 14'(offs[i])};
				bus_cycle(a, 1'b1, '0, (page_slot(4'(p)) < 0) ? "rom_unmapped" : "rom_read");
			end
		end
		foreach (rom_rejected[i]) begin
			ra = rom_rejected[i];
			bus_cycle({1'b0, slot_page(ra[16:14]), ra[13:0]}, 1'b1, '0, "rom_reject");
		end

		// Random sideways RAM traffic
		for (int i = 0; i < 200; i++) begin
			a = {2'b10, 3'($urandom), 14'($urandom)};
			ram_written.push_back(a);
			ram_write(a, DATA_W'($urandom), "ram_rw");
		end
		foreach (ram_written[i]) begin
			bus_cycle(ram_written[i], 1'b1, '0, "ram_readback");
		end

		// Same offset in every bank
		for (int i = 0; i < 8; i++) begin
			off = $urandom % PAGE_BYTES;
			for (int k = 0; k < RAM_BANKS; k++) begin
				ram_write({2'b10, 3'(k), 14'(off)}, DATA_W'($urandom), "bank_isolation");
			end
			for (int k = 0; k < RAM_BANKS; k++) begin
				bus_cycle({2'b10, 3'(k), 14'(off)}, 1'b1, '0, "bank_isolation");
			end
		end

		// nWE held low while the data moves
		a = ram_written[0];
		bus_cycle(a, 1'b0, 8'h5a, "one_write");
		for (int i = 0; i < 4; i++) begin
			bus_cycle(a, 1'b0, DATA_W'($urandom), "one_write");
		end
		bus_cycle(a, 1'b1, '0, "one_write");

		// Write attempt inside reset
		a = ram_written[1];
		begin_reset();
		bus_cycle(a, 1'b0, DATA_W'($urandom), "reset_write");
		bus_cycle(a, 1'b1, '0, "reset_write");
		end_reset();
		bus_cycle(a, 1'b1, '0, "reset_write");

		// Upper window reads zero and leaves the lower bank alone
		for (int i = 0; i < 16; i++) begin
			a     = ram_written[i + 2];
			a[17] = 1'b1;
			ram_write(a, DATA_W'($urandom), "upper_window");
			a[17] = 1'b0;
			bus_cycle(a, 1'b1, '0, "upper_window");
		end

		drain_checks();
		$display("Checks run: %0d, check errors: %0d, timeouts: %0d",
			check_count, check_errors, timeout_errors);
		if (check_errors == 0 && timeout_errors == 0 && check_count > 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- rtl/elk_mem_top.sv
/*
 * Electron external memory map, top level
 * Decoder, ROM store, eight sideways RAM banks and read mux
 */

`timescale 1ns/1ps

module elk_mem_top import elk_mem_pkg::*; (
	input  logic                    clk_sys,
	input  logic                    rst,
	// Core's external bus
	input  logic [BUS_ADDR_W-1:0]   cpu_addr,
	input  logic                    cpu_we_n,
	input  logic [DATA_W-1:0]       cpu_din,
	output logic [DATA_W-1:0]       cpu_dout,
	// ROM download port
	input  logic                    load_wr,
	input  logic [LOAD_INDEX_W-1:0] load_index,
	input  logic [ROM_ADDR_W-1:0]   load_addr,
	input  logic [DATA_W-1:0]       load_data
);

	logic [ROM_ADDR_W-1:0] rom_addr;
	logic [DATA_W-1:0]     rom_rdata;
	rd_src_t               rd_src;
	bank_idx_t             rd_bank;

	// One connection per sideways bank
	bank_if banks [RAM_BANKS] ();

	//////////////////////////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////////////////////////

	addr_decode u_decode (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.cpu_addr  (cpu_addr),
		.cpu_we_n  (cpu_we_n),
		.cpu_din   (cpu_din),
		.load_addr (load_addr),
		.banks     (banks),
		.rom_addr  (rom_addr),
		.rd_src    (rd_src),
		.rd_bank   (rd_bank)
	);

	//////////////////////////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////////////////////////

	rom_store u_rom (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.rom_addr   (rom_addr),
		.load_wr    (load_wr),
		.load_index (load_index),
		.load_data  (load_data),
		.rom_rdata  (rom_rdata)
	);

	for (genvar i = 0; i < RAM_BANKS; i++) begin : g_swram
		swram_bank u_bank (
			.clk_sys (clk_sys),
			.bus     (banks[i])
		);
	end

	// Back to the core
	read_mux u_mux (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.rd_src    (rd_src),
		.rd_bank   (rd_bank),
		.rom_rdata (rom_rdata),
		.banks     (banks),
		.cpu_dout  (cpu_dout)
	);

endmodule

//--- rtl/read_mux.sv
/*
 * Read data select
 * Source and bank registered with the memory addresses,
 * then ROM, bank or zero
 */

`timescale 1ns/1ps

module read_mux import elk_mem_pkg::*; (
	input  logic              clk_sys,
	input  logic              rst,
	input  rd_src_t           rd_src,
	input  bank_idx_t         rd_bank,
	input  logic [DATA_W-1:0] rom_rdata,
	bank_if.rd                banks [RAM_BANKS],
	output logic [DATA_W-1:0] cpu_dout
);

	rd_src_t           src_q;
	bank_idx_t         bank_q;
	logic [DATA_W-1:0] bank_rdata [RAM_BANKS];

	// Same edge as the address registers inside the memories
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			src_q <= SRC_NONE;
		end else begin
			src_q <= rd_src;
		end
		bank_q <= rd_bank;
	end

	// Flatten the interface array so it can be indexed at run time
	for (genvar i = 0; i < RAM_BANKS; i++) begin : g_rd
		assign bank_rdata[i] = banks[i].rdata;
	end

	always_comb begin
		case (src_q)
			SRC_ROM: cpu_dout = rom_rdata;
			SRC_RAM: cpu_dout = bank_rdata[bank_q];
			// Unmapped pages read zero
			default: cpu_dout = '0;
		endcase
	end

endmodule

//--- rtl/rom_store.sv
/*
 * 112 KB ROM image, seven slots
 * Reset time download write, registered read address
 */

`timescale 1ns/1ps

module rom_store import elk_mem_pkg::*; (
	input  logic                    clk_sys,
	input  logic                    rst,
	input  logic [ROM_ADDR_W-1:0]   rom_addr,
	input  logic                    load_wr,
	input  logic [LOAD_INDEX_W-1:0] load_index,
	input  logic [DATA_W-1:0]       load_data,
	output logic [DATA_W-1:0]       rom_rdata
);

	logic [DATA_W-1:0]     rom [ROM_BYTES];
	logic [ROM_ADDR_W-1:0] rd_addr;
	logic                  load_en;

	// Only index zero carries the ROM image
	// Core is held in reset for the whole download
	assign load_en = load_wr & rst & (load_index == '0);

	always_ff @(posedge clk_sys) begin
		if (load_en) begin
			rom[rom_addr] <= load_data;
		end
		rd_addr <= rom_addr;
	end

	// Slot 7 is never addressed by the decoder
	assign rom_rdata = rom[rd_addr];

endmodule

//--- rtl/swram_bank.sv
/*
 * One 16 KB sideways RAM bank
 * Synchronous write, registered read offset
 */

`timescale 1ns/1ps

module swram_bank import elk_mem_pkg::*; (
	input  logic clk_sys,
	bank_if.mem  bus
);

	logic [DATA_W-1:0]   mem [PAGE_BYTES];
	logic [OFFSET_W-1:0] rd_offset;

	// Single port block RAM shape
	always_ff @(posedge clk_sys) begin
		if (bus.wr_en) begin
			mem[bus.offset] <= bus.wdata;
		end
		rd_offset <= bus.offset;
	end

	// New data visible to the address sampled after the write
	assign bus.rdata = mem[rd_offset];

endmodule

//--- rtl/addr_decode.sv
/*
 * Bus address decoder
 * ROM page to slot lookup, RAM bank select,
 * write strobe edge detect and read source classification
 */

`timescale 1ns/1ps

module addr_decode import elk_mem_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  rst,
	input  mem_addr_t             cpu_addr,
	input  logic                  cpu_we_n,
	input  logic [DATA_W-1:0]     cpu_din,
	input  logic [ROM_ADDR_W-1:0] load_addr,
	bank_if.ctrl                  banks [RAM_BANKS],
	output logic [ROM_ADDR_W-1:0] rom_addr,
	output rd_src_t               rd_src,
	output bank_idx_t             rd_bank
);

	logic [SLOT_W-1:0] slot;
	logic              rom_hit;
	logic              ram_hit;
	logic              we_prev;
	logic              wr_fire;

	//////////////////////////////////////////////////////////////////////
	// ROM view
	//////////////////////////////////////////////////////////////////////

	// OS and BASIC each alias over two pages
	always_comb begin
		slot    = SLOT_MMFS;
		rom_hit = 1'b1;
		case (cpu_addr.rom.rom_page)
			4'b0100:          slot = SLOT_MMFS;
			4'b1000, 4'b1001: slot = SLOT_OS;
			4'b1010, 4'b1011: slot = SLOT_BASIC;
			4'b1100:          slot = SLOT_PRES;
			4'b1101:          slot = SLOT_SPARE0;
			4'b1110:          slot = SLOT_SPARE1;
			4'b1111:          slot = SLOT_MODE7;
			default:          rom_hit = 1'b0;
		endcase
	end

	// Download owns the ROM address while reset is held
	assign rom_addr = rst ? load_addr : {slot, cpu_addr.rom.offset};

	//////////////////////////////////////////////////////////////////////
	// RAM view and write strobe
	//////////////////////////////////////////////////////////////////////

	// Upper half of the RAM window is not populated
	assign ram_hit = cpu_addr.ram.is_ram & ~cpu_addr.ram.ram_hi;

	// Previous nWE sample, idles high
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			we_prev <= 1'b1;
		end else begin
			we_prev <= cpu_we_n;
		end
	end

	// High to low on nWE, one write only
	assign wr_fire = ram_hit & we_prev & ~cpu_we_n & ~rst;

	for (genvar i = 0; i < RAM_BANKS; i++) begin : g_bank
		assign banks[i].wr_en  = wr_fire && (cpu_addr.ram.bank == bank_idx_t'(i));
		assign banks[i].offset = cpu_addr.ram.offset;
		assign banks[i].wdata  = cpu_din;
	end

	// Read source for the mux
	always_comb begin
		if (cpu_addr.ram.is_ram) begin
			rd_src = ram_hit ? SRC_RAM : SRC_NONE;
		end else begin
			rd_src = rom_hit ? SRC_ROM : SRC_NONE;
		end
	end

	assign rd_bank = cpu_addr.ram.bank;

endmodule

//--- rtl/bank_if.sv
/*
 * One sideways RAM bank connection
 * Write side from the decoder, read data to the mux
 */

`timescale 1ns/1ps

interface bank_if import elk_mem_pkg::*; ();

	// Write strobe, one cycle per falling edge of the core's nWE
	logic                wr_en;
	// Offset is also the read address
	logic [OFFSET_W-1:0] offset;
	logic [DATA_W-1:0]   wdata;
	// Byte at the registered offset
	logic [DATA_W-1:0]   rdata;

	// Decoder side
	modport ctrl (
		output wr_en,
		output offset,
		output wdata
	);

	// Bank storage side
	modport mem (
		input  wr_en,
		input  offset,
		input  wdata,
		output rdata
	);

	// Read mux side
	modport rd (
		input  rdata
	);

endinterface

//--- rtl/elk_mem_pkg.sv
/*
 * Shared definitions for the Electron external memory map
 * Widths, counts, ROM slot numbers, bus address union,
 * RAM bank index and read source types
 */

package elk_mem_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths and counts
	//////////////////////////////////////////////////////////////////////

	// Byte wide bus and memories
	localparam int DATA_W       = 8;
	// Offset inside one 16 KB page
	localparam int OFFSET_W     = 14;
	localparam int PAGE_BYTES   = 1 << OFFSET_W;
	// External bus from the core
	localparam int BUS_ADDR_W   = 19;
	localparam int PAGE_W       = 4;
	// ROM image, seven 16 KB slots
	localparam int ROM_SLOTS    = 7;
	localparam int SLOT_W       = 3;
	localparam int ROM_ADDR_W   = SLOT_W + OFFSET_W;
	localparam int ROM_BYTES    = ROM_SLOTS * PAGE_BYTES;
	// Sideways RAM
	localparam int RAM_BANKS    = 8;
	localparam int BANK_W       = 3;
	// Download port index
	localparam int LOAD_INDEX_W = 8;

	//////////////////////////////////////////////////////////////////////
	// ROM slot numbers, in image order
	//////////////////////////////////////////////////////////////////////

	localparam logic [SLOT_W-1:0] SLOT_MMFS   = 3'd0;
	localparam logic [SLOT_W-1:0] SLOT_OS     = 3'd1;
	localparam logic [SLOT_W-1:0] SLOT_BASIC  = 3'd2;
	localparam logic [SLOT_W-1:0] SLOT_PRES   = 3'd3;
	localparam logic [SLOT_W-1:0] SLOT_SPARE0 = 3'd4;
	localparam logic [SLOT_W-1:0] SLOT_SPARE1 = 3'd5;
	localparam logic [SLOT_W-1:0] SLOT_MODE7  = 3'd6;

	//////////////////////////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////////////////////////

	typedef logic [BANK_W-1:0] bank_idx_t;

	// Bit 18 clear, page picks a ROM slot
	typedef struct packed {
		logic                is_ram;
		logic [PAGE_W-1:0]   rom_page;
		logic [OFFSET_W-1:0] offset;
	} rom_view_t;

	// Bit 18 set, ram_hi must be clear for a real bank
	typedef struct packed {
		logic                is_ram;
		logic                ram_hi;
		bank_idx_t           bank;
		logic [OFFSET_W-1:0] offset;
	} ram_view_t;

	// Same 19 bits, two decodes
	typedef union packed {
		rom_view_t rom;
		ram_view_t ram;
	} mem_addr_t;

	// What the read mux returns one cycle later
	typedef enum logic [1:0] {
		SRC_NONE,
		SRC_ROM,
		SRC_RAM
	} rd_src_t;

endpackage
